//--- source/emrd_pkg.sv
// Shared widths, emesh and AXI read channel structs, and queue entry formats for the read bridge
package emrd_pkg;

   //########################################
   // Bus widths
   //########################################
   localparam int MAW  = 32;                 // Emesh and AXI address width
   localparam int MDW  = 64;                 // AXI data width, eight byte lanes
   localparam int MIDW = 6;                  // AXI ID width

   // Emesh transaction, access bit travels separately
   typedef struct packed {
      logic           write;                 // High for a write
      logic [1:0]     datamode;              // 0 byte, 1 half, 2 word, 3 double
      logic [3:0]     ctrlmode;
      logic [MAW-1:0] dstaddr;
      logic [MAW-1:0] srcaddr;
      logic [31:0]    data;
   } emesh_pkt_t;

   //########################################
   // AXI3 read channels
   //########################################
   typedef struct packed {
      logic [MIDW-1:0] arid;
      logic [MAW-1:0]  araddr;
      logic [3:0]      arlen;                // Beats minus one
      logic [2:0]      arsize;               // Log2 of bytes per beat
      logic [1:0]      arburst;
      logic [1:0]      arlock;
      logic [3:0]      arcache;
      logic [2:0]      arprot;
   } ar_chan_t;

   typedef struct packed {
      logic [MIDW-1:0] rid;
      logic [MDW-1:0]  rdata;
      logic [1:0]      rresp;
      logic            rlast;
   } r_chan_t;

   //########################################
   // Queue entries
   //########################################
   // Address queue, target of the read
   typedef struct packed {
      logic [MAW-1:0] addr;
      logic [1:0]     datamode;
   } ach_entry_t;

   // Write-back queue, where the answer goes and how it is cut
   typedef struct packed {
      logic [3:0]     ctrlmode;
      logic [MAW-1:0] srcaddr;
      logic [2:0]     lane;                  // Low bits of dstaddr
      logic [1:0]     datamode;
   } wb_entry_t;

endpackage

//--- source/sync_fifo.sv
// Single-clock circular-buffer FIFO with a type-parameterized payload
`timescale 1ns/1ps

module sync_fifo #(
   parameter type T  = logic [63:0],         // Payload type
   parameter int  AW = 2                     // Log2 of depth
)
(
   input  logic eclk,
   input  logic reset,
   input  logic wr,                          // Push, caller gates by full
   input  T     wr_data,
   output logic full,
   input  logic rd,                          // Pop head entry
   output T     rd_data,                     // Head, valid while not empty
   output logic empty
);

   localparam int DEPTH = 2**AW;

   T            mem [DEPTH];                 // Storage array
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;                     // Occupancy, 0 to DEPTH
   logic          do_wr;
   logic          do_rd;

   // Guard against misuse at the edges
   assign do_wr = wr & ~full;
   assign do_rd = rd & ~empty;

   // Count reaches DEPTH only when its top bit is set
   assign full  = count[AW];
   assign empty = (count == '0);

   assign rd_data = mem[rd_ptr];             // Show-ahead head

   //########################################
   // Storage
   //########################################
   always_ff @(posedge eclk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

   //########################################
   // Pointers and occupancy
   //########################################
   always_ff @(posedge eclk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;         // Wraps at DEPTH
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                       // Idle or push and pop together
         endcase
      end
   end

endmodule

//--- source/emesh_rd_capture.sv
// Emesh read request capture, splits each read into an address entry and a write-back entry
`timescale 1ns/1ps

module emesh_rd_capture
   import emrd_pkg::*;
(
   input  logic       eclk,
   input  logic       reset,
   input  logic       req_access,
   input  emesh_pkt_t req,
   output logic       rd_wait,
   input  logic       ach_full,
   input  logic       wb_full,
   output logic       ach_wr,
   output ach_entry_t ach_data,
   output logic       wb_wr,
   output wb_entry_t  wb_data
);

   logic       accept;                       // Read taken this edge
   logic       cap_valid;                    // Capture register holds a read
   ach_entry_t cap_ach;
   wb_entry_t  cap_wb;

   // Stall the mesh while either queue is out of room
   assign rd_wait = ach_full | wb_full;

   // Reads only, writes pass by untouched
   assign accept = req_access & ~req.write & ~rd_wait;

   //########################################
   // Capture register
   //########################################
   always_ff @(posedge eclk or posedge reset)
   begin
      if (reset)
         cap_valid <= 1'b0;
      else if (~rd_wait)
         cap_valid <= accept;                // Hold while waiting
   end

   always_ff @(posedge eclk)
   begin
      if (accept)
      begin
         cap_ach.addr     <= req.dstaddr;
         cap_ach.datamode <= req.datamode;
         cap_wb.ctrlmode  <= req.ctrlmode;
         cap_wb.srcaddr   <= req.srcaddr;    // Return address
         cap_wb.lane      <= req.dstaddr[2:0];
         cap_wb.datamode  <= req.datamode;
      end
   end

   //########################################
   // Queue writes
   //########################################
   // Both queues written together so they stay paired
   assign ach_wr   = cap_valid & ~rd_wait;
   assign wb_wr    = cap_valid & ~rd_wait;
   assign ach_data = cap_ach;
   assign wb_data  = cap_wb;

endmodule

//--- source/axi_ar_issue.sv
// AXI read-address issuer, pops the address queue into a held single-beat INCR request
`timescale 1ns/1ps

module axi_ar_issue
   import emrd_pkg::*;
(
   input  logic       eclk,
   input  logic       reset,
   input  logic       fifo_empty,
   input  ach_entry_t fifo_data,
   output logic       fifo_rd,
   output ar_chan_t   ar,
   output logic       arvalid,
   input  logic       arready
);

   ach_entry_t ar_hold;                      // Entry being offered
   logic       advance;                      // Slot free or leaving now

   assign advance = ~arvalid | arready;
   assign fifo_rd = ~fifo_empty & advance;

   //########################################
   // Holding register
   //########################################
   always_ff @(posedge eclk or posedge reset)
   begin
      if (reset)
         arvalid <= 1'b0;
      else if (advance)
         arvalid <= ~fifo_empty;             // Refill or go idle
   end

   always_ff @(posedge eclk)
   begin
      if (fifo_rd)
         ar_hold <= fifo_data;
   end

   //########################################
   // Channel fields
   //########################################
   always_comb
   begin
      ar.arid    = '0;                       // In-order, single ID
      ar.araddr  = ar_hold.addr;
      ar.arlen   = 4'd0;                     // One beat
      ar.arsize  = {1'b0, ar_hold.datamode}; // Bytes = 1 << datamode
      ar.arburst = 2'b01;                    // INCR
      ar.arlock  = 2'b00;                    // Normal access
      ar.arcache = 4'b0000;
      ar.arprot  = 3'b000;                   // Unprivileged, secure, data
   end

endmodule

//--- source/read_align.sv
// Read return path, buffers AXI beats, aligns them to the request and emits emesh writes
`timescale 1ns/1ps

module read_align
   import emrd_pkg::*;
#(
   parameter int DCH_AW = 2                  // Log2 depth of the data queue
)
(
   input  logic       eclk,
   input  logic       reset,
   input  r_chan_t    r,
   input  logic       rvalid,
   output logic       rready,
   input  logic       wb_empty,
   input  wb_entry_t  wb_data,
   output logic       wb_rd,
   input  logic       wr_wait,
   output logic       rsp_access,
   output emesh_pkt_t rsp
);

   logic           dch_full;
   logic           dch_empty;
   logic [MDW-1:0] dch_out;
   logic           beat_valid;               // Beat register occupied
   logic [MDW-1:0] beat_data;
   logic           pop;                      // Data and write-back popped together
   logic           s1_valid;
   logic [MDW-1:0] s1_data;                  // Raw beat after pop
   wb_entry_t      s1_wb;
   logic [MDW-1:0] algn;
   logic           s2_valid;
   logic [MDW-1:0] s2_data;                  // Aligned beat
   wb_entry_t      s2_wb;

   //########################################
   // Beat register and data queue
   //########################################
   assign rready = ~dch_full;

   // Beat waits here while the queue is full
   always_ff @(posedge eclk or posedge reset)
   begin
      if (reset)
         beat_valid <= 1'b0;
      else if (~dch_full)
         beat_valid <= rvalid;               // rready is high here
   end

   always_ff @(posedge eclk)
   begin
      if (~dch_full)
         beat_data <= r.rdata;               // rid and rresp dropped
   end

   sync_fifo #(
      .T  (logic [MDW-1:0]),
      .AW (DCH_AW)
   ) u_dch (
      .eclk    (eclk),
      .reset   (reset),
      .wr      (beat_valid & ~dch_full),
      .wr_data (beat_data),
      .full    (dch_full),
      .rd      (pop),
      .rd_data (dch_out),
      .empty   (dch_empty)
   );

   //########################################
   // Pop and alignment stage
   //########################################
   assign pop   = ~dch_empty & ~wb_empty & ~wr_wait;
   assign wb_rd = pop;

   always_ff @(posedge eclk or posedge reset)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end
      else if (~wr_wait)                     // Whole pipe freezes on wait
      begin
         s1_valid <= pop;
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge eclk)
   begin
      if (pop)
      begin
         s1_data <= dch_out;
         s1_wb   <= wb_data;
      end
   end

   // Pick the requested lanes, zero extended
   always_comb
   begin
      case (s1_wb.datamode)
         2'd0:    algn = {56'd0, s1_data[{s1_wb.lane, 3'b000} +: 8]};
         2'd1:    algn = {48'd0, s1_data[{s1_wb.lane[2:1], 4'b0000} +: 16]};
         2'd2:    algn = {32'd0, s1_data[{s1_wb.lane[2], 5'b00000} +: 32]};
         default: algn = s1_data;            // Doubleword as is
      endcase
   end

   //########################################
   // Output stage
   //########################################
   always_ff @(posedge eclk)
   begin
      if (s1_valid & ~wr_wait)
      begin
         s2_data <= algn;
         s2_wb   <= s1_wb;
      end
   end

   assign rsp_access   = s2_valid & ~wr_wait;
   assign rsp.write    = 1'b1;               // Answer is a write back
   assign rsp.datamode = s2_wb.datamode;
   assign rsp.ctrlmode = s2_wb.ctrlmode;
   assign rsp.dstaddr  = s2_wb.srcaddr;      // Back to the requester
   assign rsp.srcaddr  = s2_data[63:32];     // Upper half of a double
   assign rsp.data     = s2_data[31:0];

endmodule

//--- source/axi_master_rd.sv
// Emesh to AXI3 read bridge top level, capture, queues, address issue and read return
`timescale 1ns/1ps

module axi_master_rd
   import emrd_pkg::*;
#(
   parameter int ACH_AW = 2,                 // Address queue log2 depth
   parameter int WB_AW  = 2,                 // Write-back queue log2 depth
   parameter int DCH_AW = 2                  // Data queue log2 depth
)
(
   input  logic       eclk,
   input  logic       reset,
   // Emesh request side
   input  logic       req_access,
   input  emesh_pkt_t req,
   output logic       rd_wait,
   // AXI read address
   output ar_chan_t   ar,
   output logic       arvalid,
   input  logic       arready,
   // AXI read data
   input  r_chan_t    r,
   input  logic       rvalid,
   output logic       rready,
   // Emesh response side
   output logic       rsp_access,
   output emesh_pkt_t rsp,
   input  logic       wr_wait
);

   //########################################
   // Internal wiring
   //########################################
   logic       ach_wr;
   ach_entry_t ach_wdata;
   logic       ach_full;
   logic       ach_rd;
   ach_entry_t ach_rdata;
   logic       ach_empty;
   logic       wb_wr;
   wb_entry_t  wb_wdata;
   logic       wb_full;
   logic       wb_rd;
   wb_entry_t  wb_rdata;
   logic       wb_empty;

   emesh_rd_capture u_capture (
      .eclk       (eclk),
      .reset      (reset),
      .req_access (req_access),
      .req        (req),
      .rd_wait    (rd_wait),
      .ach_full   (ach_full),
      .wb_full    (wb_full),
      .ach_wr     (ach_wr),
      .ach_data   (ach_wdata),
      .wb_wr      (wb_wr),
      .wb_data    (wb_wdata)
   );

   // Target address and size
   sync_fifo #(.T(ach_entry_t), .AW(ACH_AW)) u_ach_fifo (
      .eclk    (eclk),
      .reset   (reset),
      .wr      (ach_wr),
      .wr_data (ach_wdata),
      .full    (ach_full),
      .rd      (ach_rd),
      .rd_data (ach_rdata),
      .empty   (ach_empty)
   );

   // Return information, in request order
   sync_fifo #(.T(wb_entry_t), .AW(WB_AW)) u_wb_fifo (
      .eclk    (eclk),
      .reset   (reset),
      .wr      (wb_wr),
      .wr_data (wb_wdata),
      .full    (wb_full),
      .rd      (wb_rd),
      .rd_data (wb_rdata),
      .empty   (wb_empty)
   );

   axi_ar_issue u_ar_issue (
      .eclk       (eclk),
      .reset      (reset),
      .fifo_empty (ach_empty),
      .fifo_data  (ach_rdata),
      .fifo_rd    (ach_rd),
      .ar         (ar),
      .arvalid    (arvalid),
      .arready    (arready)
   );

   read_align #(.DCH_AW(DCH_AW)) u_read_align (
      .eclk       (eclk),
      .reset      (reset),
      .r          (r),
      .rvalid     (rvalid),
      .rready     (rready),
      .wb_empty   (wb_empty),
      .wb_data    (wb_rdata),
      .wb_rd      (wb_rd),
      .wr_wait    (wr_wait),
      .rsp_access (rsp_access),
      .rsp        (rsp)
   );

endmodule

//--- tb/tb_axi_master_rd.sv
// Directed testbench for the emesh to AXI3 read bridge with an AXI slave model and emesh sink
`timescale 1ns/1ps

module tb_axi_master_rd
   import emrd_pkg::*;
;
   logic       eclk = 1'b0;
   logic       reset = 1'b1;
   logic       req_access = 1'b0;
   emesh_pkt_t req = '0;
   logic       rd_wait;
   ar_chan_t   ar;
   logic       arvalid;
   logic       arready = 1'b0;
   r_chan_t    r = '0;
   logic       rvalid = 1'b0;
   logic       rready;
   logic       rsp_access;
   emesh_pkt_t rsp;
   logic       wr_wait = 1'b0;

   integer      seed = 32'hdaec;
   int          cycles = 0;
   bit          ar_block = 1'b0;              // Slave holds arready low
   bit          wr_toggle = 1'b0;             // Random wr_wait spans
   bit          r_taken = 1'b0;
   int          r_gap = 0;
   logic [31:0] rd_addr_q[$];                 // Addresses awaiting a beat
   ar_chan_t    exp_ar[$];
   emesh_pkt_t  exp_rsp[$];

   axi_master_rd dut (.*);

   always #5 eclk = ~eclk;

   //########################################
   // Helpers
   //########################################
   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   function automatic int rand_below(input int n);
      rand_below = int'(rand32() % 32'(n));
   endfunction

   // Lane selection from the beat {~addr, addr}
   function automatic logic [63:0] aligned(input logic [31:0] addr, input logic [1:0] dm);
      logic [63:0] beat;
      int          lane;
      beat = {~addr, addr};
      lane = int'(addr[2:0]);
      case (dm)
         2'd0:    aligned = (beat >> (8 * lane)) & 64'hff;
         2'd1:    aligned = (beat >> (16 * (lane / 2))) & 64'hffff;
         2'd2:    aligned = (beat >> (32 * (lane / 4))) & 64'hffff_ffff;
         default: aligned = beat;
      endcase
   endfunction

   task automatic abort_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp)
      begin
         $display("MISMATCH at time %0t: %s got %h expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   // One cycle, ends just after the falling edge
   task automatic next_cycle();
      @(negedge eclk);
      if (wr_toggle)
         wr_wait = (rand_below(2) == 0);
   endtask

   // Offer a read until the bridge takes it
   task automatic send_read(input logic [31:0] dst, input logic [1:0] dm);
      emesh_pkt_t p;
      emesh_pkt_t e;
      ar_chan_t   a;
      logic [63:0] al;
      logic [31:0] rv;
      rv         = rand32();
      p.write    = 1'b0;
      p.datamode = dm;
      p.ctrlmode = rv[3:0];
      p.dstaddr  = dst;
      p.srcaddr  = rand32();
      p.data     = rand32();
      req        = p;
      req_access = 1'b1;
      while (rd_wait)
         next_cycle();
      next_cycle();                           // Taken at the rising edge
      a = '0;
      a.araddr  = dst;
      a.arsize  = {1'b0, dm};
      a.arburst = 2'b01;
      exp_ar.push_back(a);
      al = aligned(dst, dm);
      e.write    = 1'b1;
      e.datamode = dm;
      e.ctrlmode = p.ctrlmode;
      e.dstaddr  = p.srcaddr;
      e.srcaddr  = al[63:32];
      e.data     = al[31:0];
      exp_rsp.push_back(e);
   endtask

   task automatic random_read();
      logic [1:0]  dm;
      logic [31:0] ad;
      ad = rand32();
      dm = ad[1:0];
      ad = rand32() & ~((32'd1 << dm) - 32'd1);   // Lane legal for the size
      send_read(ad, dm);
   endtask

   task automatic drain();
      req_access = 1'b0;
      while (exp_rsp.size() > 0)
         next_cycle();
      wr_toggle = 1'b0;
      wr_wait   = 1'b0;
      repeat (5) next_cycle();
   endtask

   //########################################
   // AXI slave model
   //########################################
   always @(negedge eclk)
   begin
      logic [31:0] a;
      if (!reset)
      begin
         if (r_taken)
            rvalid = 1'b0;
         if (!rvalid && rd_addr_q.size() > 0)
         begin
            if (r_gap > 0)
               r_gap = r_gap - 1;
            else
            begin
               a = rd_addr_q.pop_front();
               r.rdata = {~a, a};
               r.rlast = 1'b1;
               rvalid  = 1'b1;
               r_gap   = rand_below(3);
            end
         end
         arready = ar_block ? 1'b0 : (rand_below(4) != 0);
      end
      #1;
      r_taken = rvalid & rready;
      if (arvalid && arready)                 // Transfer at the next edge
      begin
         if (exp_ar.size() == 0)
         begin
            $display("ERROR: read address issued with no read pending");
            abort_run();
         end
         check_equal(64'(ar.araddr), 64'(exp_ar[0].araddr), "araddr");
         check_equal(64'(ar.arsize), 64'(exp_ar[0].arsize), "arsize");
         check_equal(64'(ar.arlen), 64'd0, "arlen");
         check_equal(64'(ar.arburst), 64'd1, "arburst");
         check_equal(64'(ar.arid), 64'(exp_ar[0].arid), "arid");
         check_equal(64'(ar.arlock), 64'(exp_ar[0].arlock), "arlock");
         check_equal(64'(ar.arcache), 64'(exp_ar[0].arcache), "arcache");
         check_equal(64'(ar.arprot), 64'(exp_ar[0].arprot), "arprot");
         rd_addr_q.push_back(ar.araddr);
         void'(exp_ar.pop_front());
      end
   end

   //########################################
   // Emesh sink and timeout
   //########################################
   always @(negedge eclk)
   begin
      emesh_pkt_t e;
      #1;
      if (rsp_access && wr_wait)
      begin
         $display("ERROR: response driven while wr_wait is high");
         abort_run();
      end
      if (rsp_access)
      begin
         if (exp_rsp.size() == 0)
         begin
            $display("ERROR: response with no read outstanding");
            abort_run();
         end
         e = exp_rsp.pop_front();
         check_equal(64'(rsp.write), 64'(e.write), "rsp write");
         check_equal(64'(rsp.datamode), 64'(e.datamode), "rsp datamode");
         check_equal(64'(rsp.ctrlmode), 64'(e.ctrlmode), "rsp ctrlmode");
         check_equal(64'(rsp.dstaddr), 64'(e.dstaddr), "rsp dstaddr");
         check_equal(64'(rsp.srcaddr), 64'(e.srcaddr), "rsp srcaddr");
         check_equal(64'(rsp.data), 64'(e.data), "rsp data");
      end
   end

   // About 200 reads at 20 cycles each
   always @(posedge eclk)
   begin
      cycles = cycles + 1;
      if (cycles >= 4000)
      begin
         $display("ERROR: timeout, the run did not finish within 4000 cycles");
         abort_run();
      end
   end

   //########################################
   // Directed tests
   //########################################
   task automatic test_reset_state();
      check_equal(64'(arvalid), 64'd0, "arvalid after reset");
      check_equal(64'(rsp_access), 64'd0, "rsp_access after reset");
      check_equal(64'(rd_wait), 64'd0, "rd_wait after reset");
      check_equal(64'(rready), 64'd1, "rready after reset");
   endtask

   task automatic test_single_reads();
      logic [31:0] base;
      for (int dm = 0; dm < 4; dm++)
         for (int lane = 0; lane < 8; lane += (1 << dm))
         begin
            base = rand32() & 32'hffff_fff8;
            send_read(base | 32'(lane), 2'(dm));
            drain();
         end
   endtask

   task automatic test_stream();
      for (int i = 0; i < 40; i++)
         random_read();
      drain();
   endtask

   task automatic test_ar_backpressure();
      int n;
      ar_block = 1'b1;
      for (int i = 0; i < 4; i++)
         random_read();
      req_access = 1'b0;
      n = 0;
      while (!rd_wait && n < 20)
      begin
         next_cycle();
         n++;
      end
      if (!rd_wait)
      begin
         $display("ERROR: rd_wait never rose with arready held low");
         abort_run();
      end
      ar_block = 1'b0;
      random_read();                          // Waits out rd_wait
      drain();
   endtask

   task automatic test_rsp_backpressure();
      wr_wait = 1'b1;
      for (int i = 0; i < 4; i++)
         random_read();
      req_access = 1'b0;
      repeat (40) next_cycle();               // Long stall, data backs up
      check_equal(64'(rready), 64'd0, "rready with data backed up");
      wr_wait = 1'b0;                         // Release the stall
      drain();
      wr_toggle = 1'b1;                       // Then random spans
      for (int i = 0; i < 12; i++)
         random_read();
      drain();
   endtask

   task automatic test_writes_ignored();
      req.write    = 1'b1;
      req.dstaddr  = rand32();
      req_access   = 1'b1;
      repeat (6) next_cycle();
      req_access   = 1'b0;
      repeat (20) next_cycle();               // Sinks flag any stray traffic
   endtask

   initial
   begin
      repeat (5) @(posedge eclk);
      @(negedge eclk);
      reset = 1'b0;
      next_cycle();
      test_reset_state();
      test_single_reads();
      test_stream();
      test_ar_backpressure();
      test_rsp_backpressure();
      test_writes_ignored();
      if (exp_rsp.size() == 0 && exp_ar.size() == 0)
      begin
         $display("Test passed");
         $finish;
      end
      else
      begin
         $display("ERROR: reads still outstanding at the end of the run");
         abort_run();
      end
   end

endmodule

//--- verilog.f
source/emrd_pkg.sv
source/sync_fifo.sv
source/emesh_rd_capture.sv
source/axi_ar_issue.sv
source/read_align.sv
source/axi_master_rd.sv
tb/tb_axi_master_rd.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the read bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_axi_master_rd \
   -f verilog.f -o sim_tb \
   && out=$(./obj_dir/sim_tb 2>&1; true) \
   && echo "$out" \
   && echo "$out" | grep -q "^Test passed$" \
   && exit 0 \
   || exit 1
